//--- design/pkt_steer_defines.svh
/*
 * Build-wide sizes for the packet steering block.
 * FIFO depth must be a power of two so the pointers wrap on their own.
 * The header layout puts dest in the low bits of the first packet word.
 */
`ifndef PKT_STEER_DEFINES_SVH
`define PKT_STEER_DEFINES_SVH

// Stream word width in bits
`define PKT_WIDTH 64

// Words held by the packet FIFO, also the longest legal packet
`define PKT_FIFO_DEPTH 32

// Number of output channels
`define PKT_NUM_PORTS 2

// Header field positions inside the first word
`define PKT_DEST_LSB 0
`define PKT_DEST_BITS 4
`define PKT_LEN_BITS 16

`endif

//--- design/pkt_steer_pkg.sv
/*
 * Shared types for the packet steering block.
 * pkt_hdr_t assumes dest sits at bit 0, with the length field right above it.
 */
`include "pkt_steer_defines.svh"

package pkt_steer_pkg;

   // One stream word
   typedef logic [`PKT_WIDTH-1:0] pkt_word_t;

   // Header word overlay, most significant field first
   typedef struct packed {
      logic [`PKT_WIDTH-`PKT_LEN_BITS-`PKT_DEST_BITS-1:0] opaque;
      // Packet length, not used for steering
      logic [`PKT_LEN_BITS-1:0]                          len;
      logic [`PKT_DEST_BITS-1:0]                         dest;
   } pkt_hdr_t;

   // Destination index as carried in the header
   typedef logic [`PKT_DEST_BITS-1:0] port_idx_t;

   // One bit per output channel
   typedef logic [`PKT_NUM_PORTS-1:0] port_mask_t;

   // Dropped packet count, saturates at all ones
   typedef logic [15:0] drop_cnt_t;

endpackage

//--- design/pkt_fifo.sv
/*
 * Store-and-forward stream FIFO with first-word-fall-through output.
 * A packet longer than the depth never completes and stalls the input for good.
 * o_pkt_present is high while at least one whole packet is stored.
 * i_clear drops all stored words in one cycle.
 */
`include "pkt_steer_defines.svh"

module pkt_fifo
   import pkt_steer_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_clear,
   // Write side
   input  pkt_word_t i_tdata,
   input  logic      i_tvalid,
   input  logic      i_tlast,
   output logic      o_tready,
   // Read side
   output pkt_word_t o_tdata,
   output logic      o_tvalid,
   output logic      o_tlast,
   input  logic      i_tready,
   // Complete packet indication
   output logic      o_pkt_present
);

   localparam int unsigned DEPTH  = `PKT_FIFO_DEPTH;
   localparam int unsigned ADDR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W  = $clog2(DEPTH + 1);

   // Word storage and the tlast bit of each word
   pkt_word_t        mem_data [DEPTH];
   logic             mem_last [DEPTH];

   logic [ADDR_W-1:0] wr_ptr_q;
   logic [ADDR_W-1:0] rd_ptr_q;
   // Words currently held
   logic [CNT_W-1:0]  fill_q;
   // Complete packets currently held
   logic [CNT_W-1:0]  pkt_cnt_q;

   logic push;
   logic pop;
   logic push_eop;
   logic pop_eop;

   // Full FIFO lowers ready, empty FIFO lowers valid
   assign o_tready = (fill_q != CNT_W'(DEPTH));
   assign o_tvalid = (fill_q != '0);

   // Head word falls through straight from storage
   assign o_tdata  = mem_data[rd_ptr_q];
   assign o_tlast  = mem_last[rd_ptr_q];

   assign push     = i_tvalid && o_tready;
   assign pop      = o_tvalid && i_tready;
   assign push_eop = push && i_tlast;
   assign pop_eop  = pop && o_tlast;

   assign o_pkt_present = (pkt_cnt_q != '0);

   // Storage write, no reset on the array
   always_ff @(posedge clk) begin
      if (push) begin
         mem_data[wr_ptr_q] <= i_tdata;
         mem_last[wr_ptr_q] <= i_tlast;
      end
   end

   // Pointers and fill level
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
      end else if (i_clear) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
      end else begin
         // Pointers wrap at the power-of-two depth
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leaves the level unchanged
         if (push && !pop) begin
            fill_q <= fill_q + 1'b1;
         end else if (pop && !push) begin
            fill_q <= fill_q - 1'b1;
         end
      end
   end

   // Packet count follows tlast in and tlast out
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pkt_cnt_q <= '0;
      end else if (i_clear) begin
         pkt_cnt_q <= '0;
      end else begin
         if (push_eop && !pop_eop) begin
            pkt_cnt_q <= pkt_cnt_q + 1'b1;
         end else if (pop_eop && !push_eop) begin
            pkt_cnt_q <= pkt_cnt_q - 1'b1;
         end
      end
   end

endmodule

//--- design/fifo_header_monitor.sv
/*
 * Watches the read port of a packet FIFO and captures the head packet's header.
 * o_header_valid is one cycle behind the FIFO port and stays high for one cycle
 * after the header beat pops, so a consumer must discount that cycle.
 */
`include "pkt_steer_defines.svh"

module fifo_header_monitor
   import pkt_steer_pkg::*;
(
   input  logic      clk,
   input  logic      i_rst_n,
   input  logic      i_clear,
   // Observed FIFO read port
   input  pkt_word_t i_tdata,
   input  logic      i_tvalid,
   input  logic      i_tready,
   input  logic      i_tlast,
   input  logic      i_pkt_present,
   // Head packet header
   output pkt_word_t o_header,
   output logic      o_header_valid
);

   typedef enum logic {
      WAIT_SOF,
      WAIT_EOF
   } mon_state_t;

   mon_state_t state_q;
   logic       beat;
   logic       load;

   assign beat = i_tvalid && i_tready;

   // Head word is a header only between packets and once the packet is whole
   assign load = i_tvalid && (state_q == WAIT_SOF) && i_pkt_present;

   // Packet boundary tracking
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= WAIT_SOF;
      end else if (i_clear) begin
         state_q <= WAIT_SOF;
      end else begin
         case (state_q)
            // Single-word packets end on their header beat
            WAIT_SOF: if (beat && !i_tlast) state_q <= WAIT_EOF;
            WAIT_EOF: if (beat && i_tlast) state_q <= WAIT_SOF;
            default:  state_q <= WAIT_SOF;
         endcase
      end
   end

   // Valid flag, refreshed every cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_header_valid <= 1'b0;
      end else if (i_clear) begin
         o_header_valid <= 1'b0;
      end else begin
         o_header_valid <= load;
      end
   end

   // Header word, only meaningful with the flag
   always_ff @(posedge clk) begin
      if (load) begin
         o_header <= i_tdata;
      end
   end

endmodule

//--- design/pkt_header_router.sv
/*
 * Steers each packet from the FIFO to the port named by its header dest field.
 * A dest at or beyond the port count drains the packet and bumps the drop count.
 * Output data and tlast are shared, o_tvalid picks the port.
 * The drop count saturates and is zeroed only by reset or i_clear.
 */
`include "pkt_steer_defines.svh"

module pkt_header_router
   import pkt_steer_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_clear,
   // Header from the monitor
   input  pkt_word_t  i_header,
   input  logic       i_header_valid,
   // FIFO read port
   input  pkt_word_t  i_tdata,
   input  logic       i_tvalid,
   input  logic       i_tlast,
   output logic       o_tready,
   // Output channels
   output pkt_word_t  o_tdata,
   output port_mask_t o_tvalid,
   output logic       o_tlast,
   input  port_mask_t i_tready,
   // Dropped packets
   output drop_cnt_t  o_drop_count
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FWD,
      ST_DROP
   } rt_state_t;

   rt_state_t  state_q;
   // One-hot port of the packet in flight
   port_mask_t sel_q;
   drop_cnt_t  drop_q;
   // A FIFO pop happened on the last edge
   logic       pop_q;

   pkt_hdr_t   hdr;
   port_idx_t  dest;
   logic       dest_ok;
   logic       hdr_take;
   logic       pop;

   assign hdr     = pkt_hdr_t'(i_header);
   assign dest    = hdr.dest;
   assign dest_ok = (dest < `PKT_NUM_PORTS);

   // Header flag right after a pop still describes the popped word
   assign hdr_take = (state_q == ST_IDLE) && i_header_valid && !pop_q;

   // FIFO ready per state, idle holds the header in place
   always_comb begin
      case (state_q)
         ST_FWD:  o_tready = |(sel_q & i_tready);
         ST_DROP: o_tready = 1'b1;
         default: o_tready = 1'b0;
      endcase
   end

   assign pop = i_tvalid && o_tready;

   // Shared data path, valid only on the chosen port
   assign o_tdata  = i_tdata;
   assign o_tlast  = i_tlast;
   assign o_tvalid = ((state_q == ST_FWD) && i_tvalid) ? sel_q : '0;

   assign o_drop_count = drop_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_IDLE;
         sel_q   <= '0;
         drop_q  <= '0;
         pop_q   <= 1'b0;
      end else if (i_clear) begin
         state_q <= ST_IDLE;
         sel_q   <= '0;
         drop_q  <= '0;
         pop_q   <= 1'b0;
      end else begin
         pop_q <= pop;
         case (state_q)
            ST_IDLE: begin
               if (hdr_take) begin
                  if (dest_ok) begin
                     sel_q   <= port_mask_t'(1) << dest;
                     state_q <= ST_FWD;
                  end else begin
                     state_q <= ST_DROP;
                     // Counted once, when the drop decision is made
                     if (drop_q != '1) begin
                        drop_q <= drop_q + 16'd1;
                     end
                  end
               end
            end
            // Both paths end when the tlast beat leaves the FIFO
            ST_FWD, ST_DROP: begin
               if (pop && i_tlast) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

endmodule

//--- design/pkt_steer_top.sv
/*
 * Packet steering block, FIFO then header monitor then router.
 * Packets must fit the FIFO depth, longer ones stall the input forever.
 * First output beat comes at least 3 cycles after the last input beat.
 */
`include "pkt_steer_defines.svh"

module pkt_steer_top
   import pkt_steer_pkg::*;
(
   input  logic       clk,
   input  logic       i_rst_n,
   input  logic       i_clear,
   // Input stream
   input  pkt_word_t  i_tdata,
   input  logic       i_tvalid,
   input  logic       i_tlast,
   output logic       o_tready,
   // Output channels with shared data
   output pkt_word_t  o_tdata,
   output port_mask_t o_tvalid,
   output logic       o_tlast,
   input  port_mask_t i_tready,
   output drop_cnt_t  o_drop_count
);

   // FIFO read port
   pkt_word_t fifo_tdata;
   logic      fifo_tvalid;
   logic      fifo_tlast;
   logic      fifo_tready;
   logic      pkt_present;

   // Head packet header
   pkt_word_t header;
   logic      header_valid;

   pkt_fifo i_fifo (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_clear       (i_clear),
      .i_tdata       (i_tdata),
      .i_tvalid      (i_tvalid),
      .i_tlast       (i_tlast),
      .o_tready      (o_tready),
      .o_tdata       (fifo_tdata),
      .o_tvalid      (fifo_tvalid),
      .o_tlast       (fifo_tlast),
      .i_tready      (fifo_tready),
      .o_pkt_present (pkt_present)
   );

   // Observes the FIFO port, never drives it
   fifo_header_monitor i_monitor (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_clear        (i_clear),
      .i_tdata        (fifo_tdata),
      .i_tvalid       (fifo_tvalid),
      .i_tready       (fifo_tready),
      .i_tlast        (fifo_tlast),
      .i_pkt_present  (pkt_present),
      .o_header       (header),
      .o_header_valid (header_valid)
   );

   pkt_header_router i_router (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_clear        (i_clear),
      .i_header       (header),
      .i_header_valid (header_valid),
      .i_tdata        (fifo_tdata),
      .i_tvalid       (fifo_tvalid),
      .i_tlast        (fifo_tlast),
      .o_tready       (fifo_tready),
      .o_tdata        (o_tdata),
      .o_tvalid       (o_tvalid),
      .o_tlast        (o_tlast),
      .i_tready       (i_tready),
      .o_drop_count   (o_drop_count)
   );

endmodule

//--- sim/pkt_steer_props.sv
/*
 * Protocol checks on the packet steering top level, attached with bind.
 * fail_cnt counts failed assertions for the testbench to inspect.
 */
`include "pkt_steer_defines.svh"

module pkt_steer_props
   import pkt_steer_pkg::*;
(
   input logic                                   clk,
   input logic                                   i_rst_n,
   input logic                                   i_clear,
   input pkt_word_t                              i_out_tdata,
   input port_mask_t                             i_out_tvalid,
   input logic                                   i_out_tlast,
   input port_mask_t                             i_out_tready,
   input logic                                   i_in_tready,
   input logic                                   i_header_valid,
   input logic                                   i_fifo_tvalid,
   input logic [$clog2(`PKT_FIFO_DEPTH+1)-1:0]   i_fifo_fill
);

   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;

   // At most one output port valid
   a_onehot_valid: assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(i_out_tvalid))
      else begin
         fail_cnt++;
         $error("several output ports valid");
      end

   // Stalled beat holds data, tlast and port
   a_stall_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      ((|(i_out_tvalid & ~i_out_tready)) && !i_clear) |=>
         ($stable(i_out_tdata) && $stable(i_out_tlast) && $stable(i_out_tvalid)))
      else begin
         fail_cnt++;
         $error("stalled output beat changed");
      end

   // Header flag needs a FIFO word one cycle earlier
   a_header_src: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_header_valid |-> $past(i_fifo_tvalid))
      else begin
         fail_cnt++;
         $error("header valid without FIFO word");
      end

   // Full FIFO takes no input
   a_full_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_fifo_fill == `PKT_FIFO_DEPTH) |-> !i_in_tready)
      else begin
         fail_cnt++;
         $error("input ready while FIFO full");
      end

endmodule

bind pkt_steer_top pkt_steer_props i_props (
   .clk            (clk),
   .i_rst_n        (i_rst_n),
   .i_clear        (i_clear),
   .i_out_tdata    (o_tdata),
   .i_out_tvalid   (o_tvalid),
   .i_out_tlast    (o_tlast),
   .i_out_tready   (i_tready),
   .i_in_tready    (o_tready),
   .i_header_valid (header_valid),
   .i_fifo_tvalid  (fifo_tvalid),
   .i_fifo_fill    (i_fifo.fill_q)
);

//--- sim/pkt_steer_tb.sv
/*
 * Testbench for the packet steering block.
 * Packets stay within 16 words, so a whole packet always fits the FIFO.
 * Inputs change on the falling edge, outputs are compared on the rising edge.
 */
`include "pkt_steer_defines.svh"

module pkt_steer_tb
   import pkt_steer_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned TIMEOUT = 2000;
   localparam int          NPORTS  = `PKT_NUM_PORTS;

   // Output ready patterns
   localparam int READY_ALL    = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_NONE   = 2;

   logic       clk = 1'b0;
   logic       i_rst_n;
   logic       i_clear;
   pkt_word_t  i_tdata;
   logic       i_tvalid;
   logic       i_tlast;
   logic       o_tready;
   pkt_word_t  o_tdata;
   port_mask_t o_tvalid;
   logic       o_tlast;
   port_mask_t i_tready;
   drop_cnt_t  o_drop_count;

   // Scoreboard, expected words and tlast bits per port
   pkt_word_t  exp_data [NPORTS][$];
   bit         exp_last [NPORTS][$];
   drop_cnt_t  exp_drops;
   int         ready_mode;

   pkt_steer_top i_dut (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (i_clear),
      .i_tdata      (i_tdata),
      .i_tvalid     (i_tvalid),
      .i_tlast      (i_tlast),
      .o_tready     (o_tready),
      .o_tdata      (o_tdata),
      .o_tvalid     (o_tvalid),
      .o_tlast      (o_tlast),
      .i_tready     (i_tready),
      .o_drop_count (o_drop_count)
   );

   always #4 clk = ~clk;

   task automatic report_error(input string msg);
      $display("ERROR @ %0t ns: %s", $time, msg);
      $display("STATUS: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s within %0d cycles", what, TIMEOUT);
      $display("STATUS: FAIL");
      $fatal(1, "stopped on timeout");
   endtask

   task automatic check_word(input pkt_word_t got, input pkt_word_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %b expected %b", what, got, exp));
      end
   endtask

   task automatic check_drops(input drop_cnt_t got, input drop_cnt_t exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %0d expected %0d", what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %b expected %b", what, got, exp));
      end
   endtask

   // Port a header word steers to, -1 for a dropped packet
   function automatic int expected_port(input pkt_word_t word);
      pkt_hdr_t hdr;
      hdr = pkt_hdr_t'(word);
      if (int'(hdr.dest) < NPORTS) begin
         return int'(hdr.dest);
      end
      return -1;
   endfunction

   function automatic bit queues_empty();
      for (int p = 0; p < NPORTS; p++) begin
         if (exp_data[p].size() != 0) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // Called on a falling edge, returns on the falling edge after the beat moved
   task automatic send_word(input pkt_word_t word, input bit last, input bit gaps);
      int unsigned cycles;
      cycles = 0;
      // Occasional idle cycle on the input
      if (gaps && ($urandom_range(3, 0) == 0)) begin
         i_tvalid = 1'b0;
         @(negedge clk);
      end
      i_tdata  = word;
      i_tvalid = 1'b1;
      i_tlast  = last;
      while (!o_tready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("input stream never became ready");
         end
      end
      @(negedge clk);
   endtask

   task automatic send_packet(input port_idx_t dest, input int unsigned len, input bit gaps);
      pkt_hdr_t  hdr;
      pkt_word_t word;
      int        port;
      hdr      = pkt_hdr_t'({$urandom, $urandom});
      hdr.len  = 16'(len);
      hdr.dest = dest;
      port     = expected_port(pkt_word_t'(hdr));
      if (port < 0) begin
         exp_drops++;
      end
      for (int i = 0; i < int'(len); i++) begin
         word = (i == 0) ? pkt_word_t'(hdr) : {$urandom, $urandom};
         if (port >= 0) begin
            exp_data[port].push_back(word);
            exp_last[port].push_back(i == int'(len) - 1);
         end
         send_word(word, i == int'(len) - 1, gaps);
      end
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
   endtask

   // All expected words out and every drop decided
   task automatic wait_drained(input string what);
      int unsigned cycles;
      cycles = 0;
      while (!(queues_empty() && (o_drop_count == exp_drops))) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            check_drops(o_drop_count, exp_drops, {what, " drop count"});
            report_timeout({what, " never drained"});
         end
      end
      check_mask(o_tvalid, '0, {what, " o_tvalid when idle"});
   endtask

   task automatic wait_full();
      int unsigned cycles;
      cycles = 0;
      while (o_tready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("FIFO never filled up");
         end
      end
   endtask

   task automatic wait_stalled_output();
      int unsigned cycles;
      cycles = 0;
      while (o_tvalid == '0) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) begin
            report_timeout("no output valid for the stored packets");
         end
      end
   endtask

   // Output ready, new value each falling edge
   always @(negedge clk) begin
      case (ready_mode)
         READY_RANDOM: i_tready = port_mask_t'($urandom);
         READY_NONE:   i_tready = '0;
         default:      i_tready = '1;
      endcase
   end

   // Bound protocol assertions
   always @(negedge clk) begin
      if (i_dut.i_props.fail_cnt != 0) begin
         report_error("assertion failed in the bound protocol checker");
      end
   end

   // Compare every accepted output beat with the head of its port queue
   always @(posedge clk) begin
      if (i_rst_n && !i_clear) begin
         for (int p = 0; p < NPORTS; p++) begin
            if (o_tvalid[p] && i_tready[p]) begin
               if (exp_data[p].size() == 0) begin
                  report_error($sformatf("unexpected beat %h on port %0d", o_tdata, p));
               end else begin
                  check_word(o_tdata, exp_data[p].pop_front(), $sformatf("port %0d data", p));
                  check_flag(o_tlast, exp_last[p].pop_front(), $sformatf("port %0d tlast", p));
               end
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h3822));
      i_rst_n    = 1'b0;
      i_clear    = 1'b0;
      i_tdata    = '0;
      i_tvalid   = 1'b0;
      i_tlast    = 1'b0;
      i_tready   = '1;
      ready_mode = READY_ALL;
      exp_drops  = '0;
      repeat (2) @(negedge clk);
      i_rst_n = 1'b1;

      // Idle outputs right after reset
      check_mask(o_tvalid, '0, "o_tvalid after reset");
      check_flag(o_tready, 1'b1, "o_tready after reset");
      check_drops(o_drop_count, '0, "drop count after reset");

      // Valid destinations only
      for (int n = 0; n < 12; n++) begin
         send_packet(port_idx_t'($urandom_range(1, 0)), $urandom_range(16, 1), 1'b0);
      end
      wait_drained("routable packets");

      // Destinations beyond the port count, all dropped
      for (int n = 0; n < 8; n++) begin
         send_packet(port_idx_t'($urandom_range(3, 2)), $urandom_range(16, 1), 1'b0);
      end
      wait_drained("dropped packets");
      check_drops(o_drop_count, exp_drops, "drop count after drops");

      // Mixed traffic with random back-pressure and input gaps
      ready_mode = READY_RANDOM;
      for (int n = 0; n < 30; n++) begin
         send_packet(port_idx_t'($urandom_range(3, 0)), $urandom_range(16, 1), 1'b1);
      end
      wait_drained("random back-pressure");
      ready_mode = READY_ALL;

      // Burst larger than the FIFO against zero ready
      ready_mode = READY_NONE;
      fork
         begin
            for (int n = 0; n < 4; n++) begin
               send_packet(port_idx_t'($urandom_range(1, 0)), $urandom_range(16, 9), 1'b0);
            end
         end
         begin
            wait_full();
            // head packet is held, not lost
            if (o_tvalid == '0) begin
               report_error("no port valid for the packet held in the full FIFO");
            end
            ready_mode = READY_ALL;
         end
      join
      wait_drained("burst after ready returns");

      // Clear with stored packets stalled at the output
      check_drops(o_drop_count, exp_drops, "drop count before clear");
      ready_mode = READY_NONE;
      for (int n = 0; n < 2; n++) begin
         send_packet(port_idx_t'($urandom_range(1, 0)), $urandom_range(16, 1), 1'b0);
      end
      wait_stalled_output();
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      // Stored packets are gone, so are their expectations
      for (int p = 0; p < NPORTS; p++) begin
         exp_data[p].delete();
         exp_last[p].delete();
      end
      exp_drops = '0;
      check_drops(o_drop_count, '0, "drop count after clear");
      check_mask(o_tvalid, '0, "o_tvalid after clear");
      check_flag(o_tready, 1'b1, "o_tready after clear");
      ready_mode = READY_ALL;
      for (int n = 0; n < 8; n++) begin
         send_packet(port_idx_t'($urandom_range(3, 0)), $urandom_range(16, 1), 1'b0);
      end
      wait_drained("traffic after clear");

      if (i_dut.i_props.fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("%0d assertion failures", i_dut.i_props.fail_cnt);
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- pkt_steer_top.f
+incdir+design
design/pkt_steer_pkg.sv
design/pkt_fifo.sv
design/fifo_header_monitor.sv
design/pkt_header_router.sv
design/pkt_steer_top.sv
sim/pkt_steer_props.sv
sim/pkt_steer_tb.sv

//--- Bender.yml
package:
  name: pkt_steer

export_include_dirs:
  - design

sources:
  # RTL in compile order
  - files:
      - design/pkt_steer_pkg.sv
      - design/pkt_fifo.sv
      - design/fifo_header_monitor.sv
      - design/pkt_header_router.sv
      - design/pkt_steer_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/pkt_steer_props.sv
      - sim/pkt_steer_tb.sv
